// ==== lc3Pkg.sv ====
package lc3Pkg;

    localparam int WORD_W = 16;
    localparam int REG_COUNT = 8;

    typedef logic [WORD_W-1:0] word_t;
    typedef logic [$clog2(REG_COUNT)-1:0] regIdx_t;

    localparam word_t RESET_PC = 16'h0000;

    // ir[15:12]
    typedef enum logic [3:0] {
        OP_BR   = 4'b0000,
        OP_ADD  = 4'b0001,
        OP_LD   = 4'b0010,
        OP_ST   = 4'b0011,
        OP_JSR  = 4'b0100,  // not supported
        OP_AND  = 4'b0101,
        OP_LDR  = 4'b0110,
        OP_STR  = 4'b0111,
        OP_RTI  = 4'b1000,  // not supported
        OP_NOT  = 4'b1001,
        OP_LDI  = 4'b1010,  // not supported
        OP_STI  = 4'b1011,  // not supported
        OP_JMP  = 4'b1100,
        OP_RES  = 4'b1101,  // reserved
        OP_LEA  = 4'b1110,
        OP_TRAP = 4'b1111   // not supported
    } opcode_t;

    typedef enum logic [4:0] {
        START,
        FETCH0,
        FETCH1,
        FETCH2,
        ALU0,
        BR0,
        JMP0,
        LEA0,
        LD0,
        LD1,
        LD2,
        LDR0,
        LDR1,
        LDR2,
        ST0,
        ST1,
        ST2,
        STR0,
        STR1,
        STR2
    } state_t;

    // ADD/AND/NOT map to ir[15:14] + 1
    typedef enum logic [1:0] {
        ALU_PASSA = 2'b00,
        ALU_ADD   = 2'b01,
        ALU_AND   = 2'b10,
        ALU_NOT   = 2'b11
    } aluOp_t;

    typedef enum logic [2:0] {
        BUS_NONE,
        BUS_PC,
        BUS_MARMUX,
        BUS_MDR,
        BUS_ALU
    } busSrc_t;

    typedef enum logic [1:0] {
        ADDR2_ZERO,
        ADDR2_OFF6,
        ADDR2_OFF9
    } addr2Sel_t;

    typedef enum logic {
        PC_INC,
        PC_EAB
    } pcSel_t;

endpackage

// ==== lc3RegFile.sv ====
module lc3RegFile (
    input  logic            clk,
    input  logic            reset,
    input  logic            we,
    input  lc3Pkg::regIdx_t wrIdx,
    input  lc3Pkg::regIdx_t rdIdxA,
    input  lc3Pkg::regIdx_t rdIdxB,
    input  lc3Pkg::word_t   wrData,
    output lc3Pkg::word_t   rdDataA,
    output lc3Pkg::word_t   rdDataB
);

    lc3Pkg::word_t regs [lc3Pkg::REG_COUNT];

    always_ff @(posedge clk or posedge reset)
    begin
        if (reset)
            regs <= '{default: '0};
        else if (we)
            regs[wrIdx] <= wrData;
    end

    // read ports see the old value until the edge
    assign rdDataA = regs[rdIdxA];
    assign rdDataB = regs[rdIdxB];

endmodule

// ==== lc3AddrUnit.sv ====
module lc3AddrUnit (
    input  lc3Pkg::word_t     ir,
    input  lc3Pkg::word_t     pc,
    input  lc3Pkg::word_t     baseReg,
    input  logic              addr1Base,
    input  lc3Pkg::addr2Sel_t addr2Sel,
    input  lc3Pkg::pcSel_t    pcSel,
    output lc3Pkg::word_t     eab,
    output lc3Pkg::word_t     pcNext
);

    lc3Pkg::word_t addr1;
    lc3Pkg::word_t addr2;
    lc3Pkg::word_t off6;
    lc3Pkg::word_t off9;

    assign off6 = {{(lc3Pkg::WORD_W - 6){ir[5]}}, ir[5:0]};
    assign off9 = {{(lc3Pkg::WORD_W - 9){ir[8]}}, ir[8:0]};

    assign addr1 = addr1Base ? baseReg : pc;  // pc is already incremented here

    always_comb
    begin
        case (addr2Sel)
            lc3Pkg::ADDR2_OFF6: addr2 = off6;
            lc3Pkg::ADDR2_OFF9: addr2 = off9;
            default:            addr2 = '0;
        endcase
    end

    assign eab = addr1 + addr2;

    assign pcNext = (pcSel == lc3Pkg::PC_EAB) ? eab : pc + lc3Pkg::word_t'(1);

endmodule

// ==== lc3Datapath.sv ====
module lc3Datapath (
    input  logic              clk,
    input  logic              reset,
    input  lc3Pkg::aluOp_t    aluOp,
    input  lc3Pkg::regIdx_t   sr1,
    input  lc3Pkg::regIdx_t   sr2,
    input  lc3Pkg::regIdx_t   dr,
    input  logic              regWe,
    input  logic              flagWe,
    input  lc3Pkg::busSrc_t   busSrc,
    input  logic              addr1Base,
    input  lc3Pkg::addr2Sel_t addr2Sel,
    input  lc3Pkg::pcSel_t    pcSel,
    input  logic              ldPc,
    input  logic              ldIr,
    input  logic              ldMar,
    input  logic              ldMdr,
    input  logic              mdrFromMem,
    input  lc3Pkg::word_t     memRdData,
    output lc3Pkg::word_t     ir,
    output lc3Pkg::word_t     pc,
    output lc3Pkg::word_t     mar,
    output lc3Pkg::word_t     mdr,
    output logic              n,
    output logic              z,
    output logic              p
);

    lc3Pkg::word_t irReg;
    lc3Pkg::word_t regA;
    lc3Pkg::word_t regB;
    lc3Pkg::word_t imm5;
    lc3Pkg::word_t aluB;
    lc3Pkg::word_t aluOut;
    lc3Pkg::word_t eab;
    lc3Pkg::word_t pcNext;
    lc3Pkg::word_t bus;
    logic [2:0]    nzpNext;

    lc3RegFile regFile (
        .clk     (clk),
        .reset   (reset),
        .we      (regWe),
        .wrIdx   (dr),
        .rdIdxA  (sr1),
        .rdIdxB  (sr2),
        .wrData  (bus),
        .rdDataA (regA),
        .rdDataB (regB)
    );

    lc3AddrUnit addrUnit (
        .ir        (irReg),
        .pc        (pc),
        .baseReg   (regA),
        .addr1Base (addr1Base),
        .addr2Sel  (addr2Sel),
        .pcSel     (pcSel),
        .eab       (eab),
        .pcNext    (pcNext)
    );

    // decode sees the fetched word already in FETCH2
    assign ir = ldIr ? mdr : irReg;

    assign imm5 = {{(lc3Pkg::WORD_W - 5){irReg[4]}}, irReg[4:0]};
    assign aluB = irReg[5] ? imm5 : regB;

    always_comb
    begin
        case (aluOp)
            lc3Pkg::ALU_ADD: aluOut = regA + aluB;
            lc3Pkg::ALU_AND: aluOut = regA & aluB;
            lc3Pkg::ALU_NOT: aluOut = ~regA;
            default:         aluOut = regA;
        endcase
    end

    always_comb
    begin
        case (busSrc)
            lc3Pkg::BUS_PC:     bus = pc;
            lc3Pkg::BUS_MARMUX: bus = eab;
            lc3Pkg::BUS_MDR:    bus = mdr;
            lc3Pkg::BUS_ALU:    bus = aluOut;
            default:            bus = '0;
        endcase
    end

    assign nzpNext = (bus == '0) ? 3'b010 : (bus[lc3Pkg::WORD_W-1] ? 3'b100 : 3'b001);

    always_ff @(posedge clk or posedge reset)
    begin
        if (reset)
        begin
            irReg     <= '0;
            pc        <= lc3Pkg::RESET_PC;
            mar       <= '0;
            mdr       <= '0;
            {n, z, p} <= 3'b000;
        end
        else
        begin
            if (ldIr)
                irReg <= mdr;
            if (ldPc)
                pc <= pcNext;
            if (ldMar)
                mar <= bus;
            if (ldMdr)
                mdr <= mdrFromMem ? memRdData : bus;
            if (flagWe)
                {n, z, p} <= nzpNext;
        end
    end

    // flags are only written from a real bus value
    assert property (@(posedge clk) disable iff (reset)
        flagWe |-> (busSrc != lc3Pkg::BUS_NONE));

endmodule

// ==== lc3Control.sv ====
module lc3Control (
    input  logic               clk,
    input  logic               reset,
    input  lc3Pkg::word_t      ir,
    input  logic               n,
    input  logic               z,
    input  logic               p,
    output lc3Pkg::aluOp_t     aluOp,
    output lc3Pkg::regIdx_t    sr1,
    output lc3Pkg::regIdx_t    sr2,
    output lc3Pkg::regIdx_t    dr,
    output logic               regWe,
    output logic               flagWe,
    output lc3Pkg::busSrc_t    busSrc,
    output logic               addr1Base,
    output lc3Pkg::addr2Sel_t  addr2Sel,
    output lc3Pkg::pcSel_t     pcSel,
    output logic               ldPc,
    output logic               ldIr,
    output logic               ldMar,
    output logic               ldMdr,
    output logic               mdrFromMem,
    output logic               memWe
);

    lc3Pkg::state_t  state;
    lc3Pkg::state_t  nextState;
    lc3Pkg::opcode_t opcode;
    logic            branchTaken;

    assign opcode = lc3Pkg::opcode_t'(ir[15:12]);
    assign branchTaken = (ir[11] & n) | (ir[10] & z) | (ir[9] & p);

    always_ff @(posedge clk or posedge reset)
    begin
        if (reset)
            state <= lc3Pkg::START;
        else
            state <= nextState;
    end

    always_comb
    begin
        nextState = lc3Pkg::FETCH0;  // one-cycle states and dropped opcodes
        case (state)
            lc3Pkg::FETCH0: nextState = lc3Pkg::FETCH1;
            lc3Pkg::FETCH1: nextState = lc3Pkg::FETCH2;
            lc3Pkg::FETCH2:
            begin
                case (opcode)
                    lc3Pkg::OP_ADD, lc3Pkg::OP_AND, lc3Pkg::OP_NOT: nextState = lc3Pkg::ALU0;
                    lc3Pkg::OP_BR:  nextState = lc3Pkg::BR0;
                    lc3Pkg::OP_JMP: nextState = lc3Pkg::JMP0;
                    lc3Pkg::OP_LEA: nextState = lc3Pkg::LEA0;
                    lc3Pkg::OP_LD:  nextState = lc3Pkg::LD0;
                    lc3Pkg::OP_LDR: nextState = lc3Pkg::LDR0;
                    lc3Pkg::OP_ST:  nextState = lc3Pkg::ST0;
                    lc3Pkg::OP_STR: nextState = lc3Pkg::STR0;
                    lc3Pkg::OP_JSR, lc3Pkg::OP_LDI, lc3Pkg::OP_STI,
                    lc3Pkg::OP_TRAP, lc3Pkg::OP_RTI, lc3Pkg::OP_RES:
                        nextState = lc3Pkg::FETCH0;  // no-op
                    default: nextState = lc3Pkg::FETCH0;
                endcase
            end
            lc3Pkg::LD0:  nextState = lc3Pkg::LD1;
            lc3Pkg::LD1:  nextState = lc3Pkg::LD2;
            lc3Pkg::LDR0: nextState = lc3Pkg::LDR1;
            lc3Pkg::LDR1: nextState = lc3Pkg::LDR2;
            lc3Pkg::ST0:  nextState = lc3Pkg::ST1;
            lc3Pkg::ST1:  nextState = lc3Pkg::ST2;
            lc3Pkg::STR0: nextState = lc3Pkg::STR1;
            lc3Pkg::STR1: nextState = lc3Pkg::STR2;
            default:      nextState = lc3Pkg::FETCH0;
        endcase
    end

    always_comb
    begin
        aluOp      = lc3Pkg::ALU_PASSA;
        sr1        = ir[8:6];
        sr2        = ir[2:0];
        dr         = ir[11:9];
        regWe      = 1'b0;
        flagWe     = 1'b0;
        busSrc     = lc3Pkg::BUS_NONE;
        addr1Base  = 1'b0;               // pc
        addr2Sel   = lc3Pkg::ADDR2_ZERO;
        pcSel      = lc3Pkg::PC_INC;
        ldPc       = 1'b0;
        ldIr       = 1'b0;
        ldMar      = 1'b0;
        ldMdr      = 1'b0;
        mdrFromMem = 1'b0;
        memWe      = 1'b0;
        case (state)
            lc3Pkg::FETCH0:
            begin
                busSrc = lc3Pkg::BUS_PC;
                ldMar  = 1'b1;
                ldPc   = 1'b1;  // pc + 1
            end
            lc3Pkg::FETCH1, lc3Pkg::LD1, lc3Pkg::LDR1:
            begin
                ldMdr      = 1'b1;
                mdrFromMem = 1'b1;
            end
            lc3Pkg::FETCH2: ldIr = 1'b1;
            lc3Pkg::ALU0:
            begin
                aluOp  = lc3Pkg::aluOp_t'(ir[15:14] + 2'b01);
                busSrc = lc3Pkg::BUS_ALU;
                regWe  = 1'b1;
                flagWe = 1'b1;
            end
            lc3Pkg::BR0:
            begin
                addr2Sel = lc3Pkg::ADDR2_OFF9;
                pcSel    = lc3Pkg::PC_EAB;
                ldPc     = branchTaken;
            end
            lc3Pkg::JMP0:
            begin
                addr1Base = 1'b1;  // base reg + 0
                pcSel     = lc3Pkg::PC_EAB;
                ldPc      = 1'b1;
            end
            lc3Pkg::LEA0:
            begin
                addr2Sel = lc3Pkg::ADDR2_OFF9;
                busSrc   = lc3Pkg::BUS_MARMUX;
                regWe    = 1'b1;
                flagWe   = 1'b1;
            end
            lc3Pkg::LD0, lc3Pkg::ST0:
            begin
                addr2Sel = lc3Pkg::ADDR2_OFF9;
                busSrc   = lc3Pkg::BUS_MARMUX;
                ldMar    = 1'b1;
            end
            lc3Pkg::LDR0, lc3Pkg::STR0:
            begin
                addr1Base = 1'b1;
                addr2Sel  = lc3Pkg::ADDR2_OFF6;
                busSrc    = lc3Pkg::BUS_MARMUX;
                ldMar     = 1'b1;
            end
            lc3Pkg::LD2, lc3Pkg::LDR2:
            begin
                busSrc = lc3Pkg::BUS_MDR;
                regWe  = 1'b1;
                flagWe = 1'b1;
            end
            lc3Pkg::ST1, lc3Pkg::STR1:
            begin
                sr1    = ir[11:9];  // source register passes through the ALU
                busSrc = lc3Pkg::BUS_ALU;
                ldMdr  = 1'b1;
            end
            lc3Pkg::ST2, lc3Pkg::STR2: memWe = 1'b1;
            default: ;
        endcase
    end

    // the store address must stay put while memory is written
    assert property (@(posedge clk) disable iff (reset) !(memWe && ldMar));

    assert property (@(posedge clk) disable iff (reset)
        !$isunknown(state) && (state <= lc3Pkg::STR2));

endmodule

// ==== lc3Top.sv ====
module lc3Top (
    input  logic          clk,
    input  logic          reset,
    input  lc3Pkg::word_t memRdData,
    output lc3Pkg::word_t memAddr,
    output lc3Pkg::word_t memWrData,
    output lc3Pkg::word_t pc,
    output logic          memWe
);

    lc3Pkg::word_t     ir;
    logic              n;
    logic              z;
    logic              p;
    lc3Pkg::aluOp_t    aluOp;
    lc3Pkg::regIdx_t   sr1;
    lc3Pkg::regIdx_t   sr2;
    lc3Pkg::regIdx_t   dr;
    logic              regWe;
    logic              flagWe;
    lc3Pkg::busSrc_t   busSrc;
    logic              addr1Base;
    lc3Pkg::addr2Sel_t addr2Sel;
    lc3Pkg::pcSel_t    pcSel;
    logic              ldPc;
    logic              ldIr;
    logic              ldMar;
    logic              ldMdr;
    logic              mdrFromMem;

    lc3Control control (
        .clk        (clk),
        .reset      (reset),
        .ir         (ir),
        .n          (n),
        .z          (z),
        .p          (p),
        .aluOp      (aluOp),
        .sr1        (sr1),
        .sr2        (sr2),
        .dr         (dr),
        .regWe      (regWe),
        .flagWe     (flagWe),
        .busSrc     (busSrc),
        .addr1Base  (addr1Base),
        .addr2Sel   (addr2Sel),
        .pcSel      (pcSel),
        .ldPc       (ldPc),
        .ldIr       (ldIr),
        .ldMar      (ldMar),
        .ldMdr      (ldMdr),
        .mdrFromMem (mdrFromMem),
        .memWe      (memWe)
    );

    // memory address is the MAR, write data the MDR
    lc3Datapath datapath (
        .clk        (clk),
        .reset      (reset),
        .aluOp      (aluOp),
        .sr1        (sr1),
        .sr2        (sr2),
        .dr         (dr),
        .regWe      (regWe),
        .flagWe     (flagWe),
        .busSrc     (busSrc),
        .addr1Base  (addr1Base),
        .addr2Sel   (addr2Sel),
        .pcSel      (pcSel),
        .ldPc       (ldPc),
        .ldIr       (ldIr),
        .ldMar      (ldMar),
        .ldMdr      (ldMdr),
        .mdrFromMem (mdrFromMem),
        .memRdData  (memRdData),
        .ir         (ir),
        .pc         (pc),
        .mar        (memAddr),
        .mdr        (memWrData),
        .n          (n),
        .z          (z),
        .p          (p)
    );

endmodule

// ==== tbLc3.sv ====
module tbLc3;

    localparam int ROWS = 14;
    localparam int PROG_WORDS = 8;
    localparam int MEM_WORDS = 256;
    localparam int DATA_ADDR = 'h40;
    localparam int ROW_LIMIT = PROG_WORDS * 6 + 10;  // worst case cycles per row
    localparam int TIMEOUT_CYCLES = ROWS * ROW_LIMIT;

    logic          clk = 1'b0;
    logic          reset;
    lc3Pkg::word_t memRdData;
    lc3Pkg::word_t memAddr;
    lc3Pkg::word_t memWrData;
    lc3Pkg::word_t pc;
    logic          memWe;

    lc3Pkg::word_t mem [MEM_WORDS];
    logic          loadReq;
    int            curRow;
    int            seed;
    int            valueErrors;
    int            otherErrors;
    int            totalCycles = 0;

    // program table
    string         names [ROWS];
    lc3Pkg::word_t prog [ROWS][PROG_WORDS];
    lc3Pkg::word_t dataWord [ROWS];
    lc3Pkg::word_t expAddr [ROWS];
    lc3Pkg::word_t expData [ROWS];
    lc3Pkg::word_t expPc [ROWS];  // store instruction address + 1
    int            expCycles [ROWS];

    lc3Top UUT (
        .clk       (clk),
        .reset     (reset),
        .memRdData (memRdData),
        .memAddr   (memAddr),
        .memWrData (memWrData),
        .pc        (pc),
        .memWe     (memWe)
    );

    always #4 clk = ~clk;

    assign memRdData = mem[memAddr[7:0]];  // combinational read

    always @(posedge clk)
    begin
        if (loadReq)
        begin
            for (int a = 0; a < MEM_WORDS; a++)
                mem[a] <= fillWord(8'(a));
            for (int i = 0; i < PROG_WORDS; i++)
                mem[i] <= prog[curRow][i];
            mem[DATA_ADDR] <= dataWord[curRow];
        end
        else if (memWe)
            mem[memAddr[7:0]] <= memWrData;
    end

    always @(negedge clk)
    begin
        totalCycles = totalCycles + 1;
        if (totalCycles > TIMEOUT_CYCLES)
        begin
            $display("timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display("Verification failed");
            $finish;
        end
    end

    // reserved opcode, so stray fetches do nothing
    function automatic lc3Pkg::word_t fillWord(input logic [7:0] addr);
        return {8'hD0, addr};
    endfunction

    function automatic lc3Pkg::word_t aluWord(input lc3Pkg::opcode_t op,
        input lc3Pkg::regIdx_t d, input lc3Pkg::regIdx_t s, input logic immForm,
        input logic [4:0] low);
        return {op, d, s, immForm, low};
    endfunction

    function automatic lc3Pkg::word_t pcRelWord(input lc3Pkg::opcode_t op,
        input lc3Pkg::regIdx_t r, input logic [8:0] off9);
        return {op, r, off9};
    endfunction

    function automatic lc3Pkg::word_t baseRelWord(input lc3Pkg::opcode_t op,
        input lc3Pkg::regIdx_t r, input lc3Pkg::regIdx_t base, input logic [5:0] off6);
        return {op, r, base, off6};
    endfunction

    task automatic checkWord(input string name, input lc3Pkg::word_t expected,
        input lc3Pkg::word_t actual);
        if (actual !== expected)
        begin
            $display("CHECK FAILED %s data: expected %h, actual %h", name, expected, actual);
            valueErrors++;
        end
    endtask

    task automatic checkAddr(input string name, input lc3Pkg::word_t expected,
        input lc3Pkg::word_t actual);
        if (actual !== expected)
        begin
            $display("CHECK FAILED %s address: expected %h, actual %h", name, expected, actual);
            valueErrors++;
        end
    endtask

    task automatic checkCycles(input string name, input int expected, input int actual);
        if (actual != expected)
        begin
            $display("CHECK FAILED %s cycles: expected %0d, actual %0d", name, expected, actual);
            valueErrors++;
        end
    endtask

    task automatic setRow(input int r, input string name, input lc3Pkg::word_t data,
        input lc3Pkg::word_t addr, input lc3Pkg::word_t value,
        input lc3Pkg::word_t storePc, input int cycles);
        names[r] = name;
        dataWord[r] = data;
        expAddr[r] = addr;
        expData[r] = value;
        expPc[r] = storePc;
        expCycles[r] = cycles;
    endtask

    // store cycle = 1 + 4 per one-cycle instr + 6 per memory instr + 3 per no-op + 6
    task automatic buildTable;
        lc3Pkg::word_t v;
        for (int r = 0; r < ROWS; r++)
            for (int i = 0; i < PROG_WORDS; i++)
                prog[r][i] = 16'h0000;  // BR with no condition bits

        v = lc3Pkg::word_t'($random(seed));
        setRow(0, "addReg", v, 16'h004D, v + (v + 16'h0005), 16'h0005, 25);
        prog[0][0] = pcRelWord(lc3Pkg::OP_LD, 3'd1, 9'h03F);          // R1 = mem[0x40]
        prog[0][1] = aluWord(lc3Pkg::OP_ADD, 3'd4, 3'd1, 1'b1, 5'h05);  // R4 = R1 + 5
        prog[0][2] = aluWord(lc3Pkg::OP_ADD, 3'd2, 3'd1, 1'b0, 5'h04);  // R2 = R1 + R4
        prog[0][3] = pcRelWord(lc3Pkg::OP_LEA, 3'd3, 9'h04C);         // R3 = 0x50
        prog[0][4] = baseRelWord(lc3Pkg::OP_STR, 3'd2, 3'd3, 6'h3D);    // offset -3

        v = lc3Pkg::word_t'($random(seed));
        setRow(1, "addImm", v, 16'h0064, v + 16'hFFF9, 16'h0004, 21);
        prog[1][0] = pcRelWord(lc3Pkg::OP_LD, 3'd1, 9'h03F);
        prog[1][1] = aluWord(lc3Pkg::OP_ADD, 3'd2, 3'd1, 1'b1, 5'h19);  // imm -7
        prog[1][2] = pcRelWord(lc3Pkg::OP_LEA, 3'd3, 9'h05D);
        prog[1][3] = baseRelWord(lc3Pkg::OP_STR, 3'd2, 3'd3, 6'h04);

        v = lc3Pkg::word_t'($random(seed));
        setRow(2, "andReg", v, 16'h0070, v & (v + 16'h0003), 16'h0005, 25);
        prog[2][0] = pcRelWord(lc3Pkg::OP_LD, 3'd1, 9'h03F);
        prog[2][1] = aluWord(lc3Pkg::OP_ADD, 3'd5, 3'd1, 1'b1, 5'h03);
        prog[2][2] = aluWord(lc3Pkg::OP_AND, 3'd2, 3'd1, 1'b0, 5'h05);  // R1 & R5
        prog[2][3] = pcRelWord(lc3Pkg::OP_LEA, 3'd3, 9'h06C);
        prog[2][4] = baseRelWord(lc3Pkg::OP_STR, 3'd2, 3'd3, 6'h00);

        v = lc3Pkg::word_t'($random(seed));
        setRow(3, "andImm", v, 16'h0049, v & 16'hFFFA, 16'h0004, 21);
        prog[3][0] = pcRelWord(lc3Pkg::OP_LD, 3'd1, 9'h03F);
        prog[3][1] = aluWord(lc3Pkg::OP_AND, 3'd2, 3'd1, 1'b1, 5'h1A);  // imm -6
        prog[3][2] = pcRelWord(lc3Pkg::OP_LEA, 3'd3, 9'h045);
        prog[3][3] = baseRelWord(lc3Pkg::OP_STR, 3'd2, 3'd3, 6'h01);

        v = lc3Pkg::word_t'($random(seed));
        setRow(4, "not", v, 16'h0057, ~v, 16'h0004, 21);
        prog[4][0] = pcRelWord(lc3Pkg::OP_LD, 3'd1, 9'h03F);
        prog[4][1] = aluWord(lc3Pkg::OP_NOT, 3'd2, 3'd1, 1'b1, 5'h1F);
        prog[4][2] = pcRelWord(lc3Pkg::OP_LEA, 3'd3, 9'h055);
        prog[4][3] = baseRelWord(lc3Pkg::OP_STR, 3'd2, 3'd3, 6'h3F);

        v = lc3Pkg::word_t'($random(seed));
        setRow(5, "ldSt", v, 16'h0080, v, 16'h0002, 13);
        prog[5][0] = pcRelWord(lc3Pkg::OP_LD, 3'd1, 9'h03F);
        prog[5][1] = pcRelWord(lc3Pkg::OP_ST, 3'd1, 9'h07E);

        // negative offset wraps below zero
        setRow(6, "leaSt", 16'h1234, 16'h0032, 16'hFFFF, 16'h0002, 11);
        prog[6][0] = pcRelWord(lc3Pkg::OP_LEA, 3'd6, 9'h1FE);
        prog[6][1] = pcRelWord(lc3Pkg::OP_ST, 3'd6, 9'h030);

        v = lc3Pkg::word_t'($random(seed));
        setRow(7, "ldrSt", v, 16'h0060, v, 16'h0003, 17);
        prog[7][0] = pcRelWord(lc3Pkg::OP_LEA, 3'd3, 9'h043);        // R3 = 0x44
        prog[7][1] = baseRelWord(lc3Pkg::OP_LDR, 3'd2, 3'd3, 6'h3C);   // 0x44 - 4
        prog[7][2] = pcRelWord(lc3Pkg::OP_ST, 3'd2, 9'h05D);

        setRow(8, "brTaken", 16'h0000, 16'h00A0, 16'h0009, 16'h0006, 19);
        prog[8][0] = aluWord(lc3Pkg::OP_AND, 3'd2, 3'd2, 1'b1, 5'h00);  // sets Z
        prog[8][1] = pcRelWord(lc3Pkg::OP_BR, 3'b010, 9'h002);
        prog[8][2] = pcRelWord(lc3Pkg::OP_ST, 3'd2, 9'h08D);           // 0x90, not taken
        prog[8][4] = aluWord(lc3Pkg::OP_ADD, 3'd2, 3'd2, 1'b1, 5'h09);
        prog[8][5] = pcRelWord(lc3Pkg::OP_ST, 3'd2, 9'h09A);           // 0xA0, taken

        setRow(9, "brNotTaken", 16'h0000, 16'h0090, 16'h0001, 16'h0003, 15);
        prog[9][0] = aluWord(lc3Pkg::OP_ADD, 3'd2, 3'd2, 1'b1, 5'h01);  // sets P
        prog[9][1] = pcRelWord(lc3Pkg::OP_BR, 3'b100, 9'h002);
        prog[9][2] = pcRelWord(lc3Pkg::OP_ST, 3'd2, 9'h08D);
        prog[9][4] = pcRelWord(lc3Pkg::OP_ST, 3'd2, 9'h09B);

        // flags all clear after reset, so even BRnzp falls through
        setRow(10, "brAfterReset", 16'h0000, 16'h0090, 16'h0000, 16'h0002, 11);
        prog[10][0] = pcRelWord(lc3Pkg::OP_BR, 3'b111, 9'h002);
        prog[10][1] = pcRelWord(lc3Pkg::OP_ST, 3'd0, 9'h08E);
        prog[10][3] = aluWord(lc3Pkg::OP_ADD, 3'd0, 3'd0, 1'b1, 5'h05);
        prog[10][4] = pcRelWord(lc3Pkg::OP_ST, 3'd0, 9'h09B);

        setRow(11, "ret", 16'h0000, 16'h00A0, 16'hFFFF, 16'h0007, 19);
        prog[11][0] = pcRelWord(lc3Pkg::OP_LEA, 3'd7, 9'h004);         // R7 = 5
        prog[11][1] = baseRelWord(lc3Pkg::OP_JMP, 3'd0, 3'd7, 6'h00);   // RET
        prog[11][2] = pcRelWord(lc3Pkg::OP_ST, 3'd0, 9'h08D);
        prog[11][5] = aluWord(lc3Pkg::OP_ADD, 3'd0, 3'd0, 1'b1, 5'h1F);
        prog[11][6] = pcRelWord(lc3Pkg::OP_ST, 3'd0, 9'h099);

        v = lc3Pkg::word_t'($random(seed)) | 16'h8000;
        setRow(12, "ldFlagN", v, 16'h00A0, v, 16'h0004, 17);
        prog[12][0] = pcRelWord(lc3Pkg::OP_LD, 3'd1, 9'h03F);
        prog[12][1] = pcRelWord(lc3Pkg::OP_BR, 3'b100, 9'h001);
        prog[12][2] = pcRelWord(lc3Pkg::OP_ST, 3'd1, 9'h08D);
        prog[12][3] = pcRelWord(lc3Pkg::OP_ST, 3'd1, 9'h09C);

        // TRAP and JSR only cost the fetch
        setRow(13, "noOps", 16'h0000, 16'h00A0, 16'h0003, 16'h0006, 21);
        prog[13][0] = aluWord(lc3Pkg::OP_ADD, 3'd2, 3'd2, 1'b1, 5'h03);
        prog[13][1] = 16'hF025;                                        // TRAP x25
        prog[13][2] = 16'h4801;                                        // JSR +1
        prog[13][3] = pcRelWord(lc3Pkg::OP_BR, 3'b001, 9'h001);
        prog[13][4] = pcRelWord(lc3Pkg::OP_ST, 3'd2, 9'h08B);
        prog[13][5] = pcRelWord(lc3Pkg::OP_ST, 3'd2, 9'h09A);
    endtask

    task automatic runRow(input int r);
        int   cycles;
        logic stored;
        cycles = 0;
        stored = 1'b0;
        @(posedge clk);
        reset <= 1'b1;
        curRow <= r;
        @(posedge clk);
        loadReq <= 1'b1;
        @(posedge clk);
        loadReq <= 1'b0;
        repeat (2) @(posedge clk);
        reset <= 1'b0;  // four cycles in reset
        while (!stored && cycles < ROW_LIMIT)
        begin
            @(negedge clk);
            cycles++;
            stored = memWe;
        end
        if (!stored)
        begin
            $display("%s: no store happened within %0d cycles", names[r], ROW_LIMIT);
            otherErrors++;
        end
        else
        begin
            checkAddr(names[r], expAddr[r], memAddr);
            checkAddr({names[r], " pc"}, expPc[r], pc);
            checkWord(names[r], expData[r], memWrData);
            checkCycles(names[r], expCycles[r], cycles);
            @(negedge clk);
            if (memWe)
            begin
                $display("%s: memWe stayed high for more than one cycle", names[r]);
                otherErrors++;
            end
            checkWord({names[r], " memory"}, expData[r], mem[expAddr[r][7:0]]);
        end
    endtask

    initial
    begin
        reset = 1'b1;
        loadReq = 1'b0;
        curRow = 0;
        seed = 49198;
        valueErrors = 0;
        otherErrors = 0;
        buildTable();
        for (int r = 0; r < ROWS; r++)
            runRow(r);
        $display("errors: %0d value mismatches, %0d other failures", valueErrors, otherErrors);
        if (valueErrors == 0 && otherErrors == 0)
            $display("Verification passed");
        else
            $display("Verification failed");
        $finish;
    end

endmodule

// ==== list.f ====
lc3Pkg.sv
lc3RegFile.sv
lc3AddrUnit.sv
lc3Datapath.sv
lc3Control.sv
lc3Top.sv
tbLc3.sv

// ==== run.sh ====
#!/bin/sh
rm -f sim.log
verilator --binary --timing --assert --top-module tbLc3 -f list.f -o simLc3 || exit 1
./obj_dir/simLc3 > sim.log 2>&1 || { cat sim.log; exit 1; }
cat sim.log
grep -q "Verification failed" sim.log && exit 1 || exit 0
